// ==== alarm_pkg.sv ====
package alarm_pkg;

   ////////////////////////////////////////
   // widths and board constants

   localparam int delay_w      = 4;   // one delay slot and the timer count
   localparam int tick_count_w = 25;  // holds 25_000_000 - 1

   localparam int unsigned board_ticks_per_second = 25_000_000;

   ////////////////////////////////////////
   // delay table

   typedef enum logic [1:0]
   {
      arm_delay       = 2'd0,
      driver_delay    = 2'd1,
      passenger_delay = 2'd2,
      alarm_on        = 2'd3
   } slot_t;

   // entry n belongs to slot n, values in seconds
   localparam logic [3:0][delay_w-1:0] default_delays = {4'd10, 4'd15, 4'd8, 4'd6};

   ////////////////////////////////////////
   // state machines

   typedef enum logic [2:0]
   {
      armed          = 3'd0,
      triggered      = 3'd1,
      sound_alarm    = 3'd2,
      expiring_alarm = 3'd3,
      disarmed       = 3'd4,
      disarmed_1     = 3'd5,
      disarmed_2     = 3'd6,
      disarmed_3     = 3'd7
   } theft_state_t;

   typedef enum logic [1:0]
   {
      light_off     = 2'd0,
      blinking      = 2'd1,
      constantly_on = 2'd2
   } lamp_mode_t;

   typedef enum logic [1:0]
   {
      pump_off      = 2'd0,
      restore_start = 2'd1,
      latch_on      = 2'd2
   } fuel_state_t;

endpackage

// ==== alarm_ref_model.sv ====
module alarm_ref_model #(
   parameter int unsigned ticks_per_second = alarm_pkg::board_ticks_per_second
) (
   input  logic                          clock_25mhz,
   input  logic                          reset_sync,
   input  logic                          ignition,
   input  logic                          driver_door,
   input  logic                          passenger_door,
   input  logic                          hidden_switch,
   input  logic                          brake_pedal,
   input  logic                          reprogram,
   input  alarm_pkg::slot_t              slot_select,
   input  logic [alarm_pkg::delay_w-1:0] new_delay,
   output logic                          alarm,
   output logic                          status_lamp_on,
   output logic                          fuel_pump_power,
   output logic [alarm_pkg::delay_w-1:0] timer_count,
   output alarm_pkg::theft_state_t       theft_state
);

   timeunit 1ns;
   timeprecision 1ps;

   logic [31:0]                   sec_count;
   logic                          tick_q;
   logic                          start_q;     // registered timer start
   alarm_pkg::slot_t              sel_q;
   logic [alarm_pkg::delay_w-1:0] delays [4];
   alarm_pkg::lamp_mode_t         lamp_q;
   logic                          phase;
   alarm_pkg::fuel_state_t        fuel_q;

   function automatic alarm_pkg::lamp_mode_t lamp_for(input alarm_pkg::theft_state_t s);
      if (s == alarm_pkg::armed)
         return alarm_pkg::blinking;
      if (s == alarm_pkg::triggered || s == alarm_pkg::sound_alarm ||
          s == alarm_pkg::expiring_alarm)
         return alarm_pkg::constantly_on;
      return alarm_pkg::light_off;
   endfunction

   always_ff @(posedge clock_25mhz)
   begin
      alarm_pkg::theft_state_t nxt;
      alarm_pkg::slot_t        nsel;
      alarm_pkg::fuel_state_t  nfuel;
      logic                    nstart;
      logic                    expd;
      logic                    doors;

      expd   = (timer_count == 4'd0) && !start_q;
      doors  = driver_door || passenger_door;
      nxt    = theft_state;
      nsel   = sel_q;
      nstart = 1'b0;
      nfuel  = fuel_q;

      ////////////////////////////////////////
      // arming rules

      if (reprogram)
         nxt = alarm_pkg::armed;
      else if (ignition && theft_state != alarm_pkg::disarmed_3)
         nxt = alarm_pkg::disarmed;   // key always wins, except during re-arm wait
      else
      begin
         case (theft_state)
            alarm_pkg::armed:
            begin
               if (driver_door || passenger_door)
               begin
                  nxt    = alarm_pkg::triggered;
                  nstart = 1'b1;
                  nsel   = driver_door ? alarm_pkg::driver_delay : alarm_pkg::passenger_delay;
               end
            end
            alarm_pkg::triggered:      if (expd) nxt = alarm_pkg::sound_alarm;
            alarm_pkg::sound_alarm:
            begin
               if (!doors)
               begin
                  nxt    = alarm_pkg::expiring_alarm;
                  nstart = 1'b1;
                  nsel   = alarm_pkg::alarm_on;
               end
            end
            alarm_pkg::expiring_alarm:
            begin
               if (expd)
                  nxt = alarm_pkg::armed;
               else if (doors)
                  nxt = alarm_pkg::sound_alarm;
            end
            alarm_pkg::disarmed:       nxt = alarm_pkg::disarmed_1;   // ignition is low here
            alarm_pkg::disarmed_1:     if (driver_door) nxt = alarm_pkg::disarmed_2;
            alarm_pkg::disarmed_2:
            begin
               if (!driver_door)
               begin
                  nxt    = alarm_pkg::disarmed_3;
                  nstart = 1'b1;
                  nsel   = alarm_pkg::arm_delay;
               end
            end
            alarm_pkg::disarmed_3:
            begin
               if (doors)
                  nxt = alarm_pkg::disarmed;
               else if (expd)
                  nxt = alarm_pkg::armed;
            end
            default:                   nxt = alarm_pkg::armed;
         endcase
      end

      // fuel pump secret sequence
      case (fuel_q)
         alarm_pkg::pump_off:      if (ignition) nfuel = alarm_pkg::restore_start;
         alarm_pkg::restore_start:
         begin
            if (!ignition)
               nfuel = alarm_pkg::pump_off;
            else if (hidden_switch && brake_pedal)
               nfuel = alarm_pkg::latch_on;
         end
         alarm_pkg::latch_on:      if (!ignition) nfuel = alarm_pkg::pump_off;
         default:                  nfuel = alarm_pkg::pump_off;
      endcase

      if (reset_sync)
      begin
         theft_state     <= alarm_pkg::armed;
         start_q         <= 1'b0;
         sel_q           <= alarm_pkg::arm_delay;
         lamp_q          <= alarm_pkg::blinking;
         alarm           <= 1'b0;
         sec_count       <= 32'd0;
         tick_q          <= 1'b0;
         timer_count     <= 4'd0;
         delays[0]       <= alarm_pkg::default_delays[0];
         delays[1]       <= alarm_pkg::default_delays[1];
         delays[2]       <= alarm_pkg::default_delays[2];
         delays[3]       <= alarm_pkg::default_delays[3];
         phase           <= 1'b0;
         status_lamp_on  <= 1'b0;
         fuel_q          <= alarm_pkg::pump_off;
         fuel_pump_power <= 1'b0;
      end
      else
      begin
         theft_state <= nxt;
         start_q     <= nstart;
         sel_q       <= nsel;
         lamp_q      <= lamp_for(nxt);
         alarm       <= (nxt == alarm_pkg::sound_alarm) || (nxt == alarm_pkg::expiring_alarm);

         ////////////////////////////////////////
         // seconds and countdown

         if (start_q || sec_count == ticks_per_second - 1)
            sec_count <= 32'd0;
         else
            sec_count <= sec_count + 32'd1;
         tick_q <= !start_q && (sec_count == ticks_per_second - 1);

         if (start_q)
            timer_count <= delays[sel_q];   // old table contents on a write edge
         else if (tick_q && timer_count != 4'd0)
            timer_count <= timer_count - 4'd1;

         if (reprogram)
            delays[slot_select] <= new_delay;

         if (lamp_q == alarm_pkg::blinking && tick_q)
            phase <= !phase;
         if (lamp_q == alarm_pkg::blinking)
            status_lamp_on <= phase;
         else
            status_lamp_on <= (lamp_q == alarm_pkg::constantly_on);

         fuel_q          <= nfuel;
         fuel_pump_power <= (nfuel == alarm_pkg::latch_on);
      end
   end

endmodule

// ==== car_alarm_top.sv ====
module car_alarm_top #(
   parameter int unsigned ticks_per_second = alarm_pkg::board_ticks_per_second
) (
   input  logic                          clock_25mhz,
   input  logic                          reset_sync,
   input  logic                          ignition,
   input  logic                          driver_door,
   input  logic                          passenger_door,
   input  logic                          hidden_switch,
   input  logic                          brake_pedal,
   input  logic                          reprogram,
   input  alarm_pkg::slot_t              slot_select,
   input  logic [alarm_pkg::delay_w-1:0] new_delay,
   output logic                          alarm,
   output logic                          status_lamp_on,
   output logic                          fuel_pump_power,
   output logic [alarm_pkg::delay_w-1:0] timer_count,
   output alarm_pkg::theft_state_t       theft_state
);

   logic                          start_timer;
   logic                          expired;
   logic                          tick;
   logic [alarm_pkg::delay_w-1:0] delay_value;
   alarm_pkg::slot_t              delay_select;
   alarm_pkg::lamp_mode_t         lamp_mode;

   ////////////////////////////////////////
   // timing path

   // a new countdown also restarts the second so it runs full length
   second_tick #(.ticks_per_second(ticks_per_second)) u_second_tick (
      .clock_25mhz (clock_25mhz),
      .reset_sync  (reset_sync),
      .restart     (start_timer),
      .tick        (tick)
   );

   interval_timer u_interval_timer (
      .clock_25mhz (clock_25mhz),
      .reset_sync  (reset_sync),
      .start_timer (start_timer),
      .delay_value (delay_value),
      .tick        (tick),
      .expired     (expired),
      .timer_count (timer_count)
   );

   delay_table u_delay_table (
      .clock_25mhz  (clock_25mhz),
      .reset_sync   (reset_sync),
      .reprogram    (reprogram),
      .slot_select  (slot_select),
      .new_delay    (new_delay),
      .delay_select (delay_select),
      .delay_value  (delay_value)
   );

   ////////////////////////////////////////
   // control and indicators

   theft_fsm u_theft_fsm (
      .clock_25mhz    (clock_25mhz),
      .reset_sync     (reset_sync),
      .reprogram      (reprogram),
      .ignition       (ignition),
      .driver_door    (driver_door),
      .passenger_door (passenger_door),
      .expired        (expired),
      .start_timer    (start_timer),
      .delay_select   (delay_select),
      .lamp_mode      (lamp_mode),
      .alarm          (alarm),
      .theft_state    (theft_state)
   );

   fuel_pump_latch u_fuel_pump_latch (
      .clock_25mhz     (clock_25mhz),
      .reset_sync      (reset_sync),
      .ignition        (ignition),
      .hidden_switch   (hidden_switch),
      .brake_pedal     (brake_pedal),
      .fuel_pump_power (fuel_pump_power)
   );

   status_lamp u_status_lamp (
      .clock_25mhz    (clock_25mhz),
      .reset_sync     (reset_sync),
      .lamp_mode      (lamp_mode),
      .tick           (tick),
      .status_lamp_on (status_lamp_on)
   );

endmodule

// ==== delay_table.sv ====
module delay_table (
   input  logic                              clock_25mhz,
   input  logic                              reset_sync,
   input  logic                              reprogram,
   input  alarm_pkg::slot_t                  slot_select,
   input  logic [alarm_pkg::delay_w-1:0]     new_delay,
   input  alarm_pkg::slot_t                  delay_select,
   output logic [alarm_pkg::delay_w-1:0]     delay_value
);

   logic [3:0][alarm_pkg::delay_w-1:0] delays;

   ////////////////////////////////////////
   // programmable slots

   always_ff @(posedge clock_25mhz)
   begin
      if (reset_sync)
      begin
         delays <= alarm_pkg::default_delays;
      end
      else if (reprogram)
      begin
         delays[slot_select] <= new_delay;   // held reprogram keeps rewriting
      end
   end

   ////////////////////////////////////////
   // read side

   // timer samples this on the start_timer edge
   assign delay_value = delays[delay_select];

endmodule

// ==== fuel_pump_latch.sv ====
module fuel_pump_latch (
   input  logic clock_25mhz,
   input  logic reset_sync,
   input  logic ignition,
   input  logic hidden_switch,
   input  logic brake_pedal,
   output logic fuel_pump_power
);

   alarm_pkg::fuel_state_t state;
   alarm_pkg::fuel_state_t next_state;

   always_comb
   begin
      next_state = state;
      case (state)
         alarm_pkg::pump_off:
         begin
            if (ignition)
               next_state = alarm_pkg::restore_start;
         end
         alarm_pkg::restore_start:
         begin
            // key turned back off before the secret combination
            if (!ignition)
               next_state = alarm_pkg::pump_off;
            else if (hidden_switch && brake_pedal)
               next_state = alarm_pkg::latch_on;
         end
         alarm_pkg::latch_on:
         begin
            if (!ignition)
               next_state = alarm_pkg::pump_off;
         end
         default:
         begin
            next_state = alarm_pkg::pump_off;
         end
      endcase
   end

   always_ff @(posedge clock_25mhz)
   begin
      if (reset_sync)
      begin
         state           <= alarm_pkg::pump_off;
         fuel_pump_power <= 1'b0;
      end
      else
      begin
         state           <= next_state;
         fuel_pump_power <= (next_state == alarm_pkg::latch_on);  // on with the latch
      end
   end

endmodule

// ==== interval_timer.sv ====
module interval_timer (
   input  logic                              clock_25mhz,
   input  logic                              reset_sync,
   input  logic                              start_timer,
   input  logic [alarm_pkg::delay_w-1:0]     delay_value,
   input  logic                              tick,
   output logic                              expired,
   output logic [alarm_pkg::delay_w-1:0]     timer_count
);

   // remaining whole seconds
   always_ff @(posedge clock_25mhz)
   begin
      if (reset_sync)
      begin
         timer_count <= '0;
      end
      else if (start_timer)
      begin
         timer_count <= delay_value;  // load wins over a tick in the same cycle
      end
      else if (tick && (timer_count != '0))
      begin
         timer_count <= timer_count - 1'b1;
      end
   end

   // a pending load hides the old zero count, so the fsm never sees
   // a stale expiry in the cycle right after it started the timer
   assign expired = (timer_count == '0) && !start_timer;

endmodule

// ==== list.f ====
alarm_pkg.sv
second_tick.sv
interval_timer.sv
delay_table.sv
theft_fsm.sv
fuel_pump_latch.sv
status_lamp.sv
car_alarm_top.sv
alarm_ref_model.sv
tb_car_alarm.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the car alarm testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 --top-module tb_car_alarm -f list.f -o sim_car_alarm
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

output=$(./obj_dir/sim_car_alarm)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$output" | grep -q "TESTBENCH PASSED"; then
   exit 0
fi
exit 1

// ==== second_tick.sv ====
module second_tick #(
   parameter int unsigned ticks_per_second = alarm_pkg::board_ticks_per_second
) (
   input  logic clock_25mhz,
   input  logic reset_sync,
   input  logic restart,
   output logic tick
);

   typedef logic [alarm_pkg::tick_count_w-1:0] count_t;

   localparam count_t last_count = count_t'(ticks_per_second - 1);

   count_t count;

   always_ff @(posedge clock_25mhz)
   begin
      if (reset_sync || restart)
      begin
         count <= '0;
         tick  <= 1'b0;
      end
      else if (count == last_count)
      begin
         count <= '0;    // wrap, one full second done
         tick  <= 1'b1;
      end
      else
      begin
         count <= count + 1'b1;
         tick  <= 1'b0;
      end
   end

endmodule

// ==== status_lamp.sv ====
module status_lamp (
   input  logic                  clock_25mhz,
   input  logic                  reset_sync,
   input  alarm_pkg::lamp_mode_t lamp_mode,
   input  logic                  tick,
   output logic                  status_lamp_on
);

   logic blink_phase;

   always_ff @(posedge clock_25mhz)
   begin
      if (reset_sync)
      begin
         blink_phase    <= 1'b0;
         status_lamp_on <= 1'b0;
      end
      else
      begin
         if ((lamp_mode == alarm_pkg::blinking) && tick)
            blink_phase <= !blink_phase;   // one toggle per second

         case (lamp_mode)
            alarm_pkg::blinking:      status_lamp_on <= blink_phase;
            alarm_pkg::constantly_on: status_lamp_on <= 1'b1;
            default:                  status_lamp_on <= 1'b0;
         endcase
      end
   end

endmodule

// ==== tb_car_alarm.sv ====
module tb_car_alarm;

   timeunit 1ns;
   timeprecision 1ps;

   localparam int stim_cycles    = 15000;
   localparam int timeout_cycles = stim_cycles + 5000;   // longest scenario is far below 5000

   logic                    clock_25mhz;
   logic                    reset_sync;
   logic                    ignition;
   logic                    driver_door;
   logic                    passenger_door;
   logic                    hidden_switch;
   logic                    brake_pedal;
   logic                    reprogram;
   alarm_pkg::slot_t        slot_select;
   logic [3:0]              new_delay;

   logic                    dut_alarm, ref_alarm;
   logic                    dut_lamp, ref_lamp;
   logic                    dut_pump, ref_pump;
   logic [3:0]              dut_count, ref_count;
   alarm_pkg::theft_state_t dut_state, ref_state;

   int                      cycle_count;
   int                      errors;
   int                      checks;
   logic [31:0]             rnd;

   car_alarm_top #(.ticks_per_second(8)) DUT (
      .clock_25mhz (clock_25mhz), .reset_sync (reset_sync), .ignition (ignition),
      .driver_door (driver_door), .passenger_door (passenger_door),
      .hidden_switch (hidden_switch), .brake_pedal (brake_pedal), .reprogram (reprogram),
      .slot_select (slot_select), .new_delay (new_delay), .alarm (dut_alarm),
      .status_lamp_on (dut_lamp), .fuel_pump_power (dut_pump),
      .timer_count (dut_count), .theft_state (dut_state)
   );

   alarm_ref_model #(.ticks_per_second(8)) u_model (
      .clock_25mhz (clock_25mhz), .reset_sync (reset_sync), .ignition (ignition),
      .driver_door (driver_door), .passenger_door (passenger_door),
      .hidden_switch (hidden_switch), .brake_pedal (brake_pedal), .reprogram (reprogram),
      .slot_select (slot_select), .new_delay (new_delay), .alarm (ref_alarm),
      .status_lamp_on (ref_lamp), .fuel_pump_power (ref_pump),
      .timer_count (ref_count), .theft_state (ref_state)
   );

   initial
   begin
      clock_25mhz = 1'b0;
      forever #20 clock_25mhz = !clock_25mhz;
   end

   always @(posedge clock_25mhz)
      cycle_count <= cycle_count + 1;

   ////////////////////////////////////////
   // stimulus helpers

   task automatic hold_inputs(input logic ign, input logic drv, input logic pas,
                              input logic hid, input logic brk, input int cycles);
      @(posedge clock_25mhz);
      ignition       <= ign;
      driver_door    <= drv;
      passenger_door <= pas;
      hidden_switch  <= hid;
      brake_pedal    <= brk;
      repeat (cycles - 1) @(posedge clock_25mhz);
   endtask

   task automatic write_slot();
      rnd = $urandom();
      @(posedge clock_25mhz);
      reprogram   <= 1'b1;
      slot_select <= alarm_pkg::slot_t'(rnd[1:0]);
      new_delay   <= rnd[7:4];
      @(posedge clock_25mhz);
      reprogram   <= 1'b0;
   endtask

   // ignition on, off, driver in and out, then wait for re-arm
   task automatic disarm_walk();
      hold_inputs(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 3 + int'($urandom() % 10));
      hold_inputs(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 3);
      hold_inputs(1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 4);
      hold_inputs(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 60 + int'($urandom() % 80));
   endtask

   // one door held into the siren then closed until expiry
   task automatic break_in();
      rnd = $urandom();
      hold_inputs(1'b0, rnd[0], !rnd[0], 1'b0, 1'b0, 140);
      hold_inputs(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 20 + int'(rnd[15:8]) % 120);
      hold_inputs(1'b0, rnd[1], 1'b0, 1'b0, 1'b0, 5);   // sometimes reopen
      hold_inputs(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 130);
   endtask

   task automatic compare_output(input string name, input logic [3:0] got,
                                 input logic [3:0] exp);
      checks++;
      if (got !== exp)
         errors++;
      assert (got === exp)
      else
         $display("mismatch at %0t ns: %s dut=%0h model=%0h", $time, name, got, exp);
   endtask

   always @(negedge clock_25mhz)
   begin
      if (!reset_sync)
      begin
         compare_output("alarm", {3'b0, dut_alarm}, {3'b0, ref_alarm});
         compare_output("status_lamp_on", {3'b0, dut_lamp}, {3'b0, ref_lamp});
         compare_output("fuel_pump_power", {3'b0, dut_pump}, {3'b0, ref_pump});
         compare_output("timer_count", dut_count, ref_count);
         compare_output("theft_state", {1'b0, dut_state}, {1'b0, ref_state});
      end
   end

   ////////////////////////////////////////
   // main sequence

   initial
   begin
      cycle_count    = 0;
      errors         = 0;
      checks         = 0;
      reset_sync     = 1'b1;
      ignition       = 1'b0;
      driver_door    = 1'b0;
      passenger_door = 1'b0;
      hidden_switch  = 1'b0;
      brake_pedal    = 1'b0;
      reprogram      = 1'b0;
      slot_select    = alarm_pkg::arm_delay;
      new_delay      = 4'd0;
      rnd            = $urandom(32'h2e9a);
      repeat (4) @(posedge clock_25mhz);
      reset_sync <= 1'b0;

      hold_inputs(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 40);   // idle while armed so the lamp blinks
      while (cycle_count < stim_cycles)
      begin
         rnd = $urandom();
         case (rnd[3:0])
            4'd0:          write_slot();
            4'd1, 4'd2:    disarm_walk();
            4'd3, 4'd4:    break_in();
            4'd5:          hold_inputs(1'b1, 1'b0, 1'b0, rnd[8], 1'b1, 10 + int'(rnd[14:10]));
            default:       hold_inputs(rnd[4] & rnd[5], rnd[6], rnd[7] & rnd[9],
                                       rnd[8], rnd[11], 1 + int'(rnd[31:16] % 40));
         endcase
      end
      hold_inputs(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 4);

      $display("errors: %0d of %0d checks", errors, checks);
      if (errors == 0)
         $display("TESTBENCH PASSED");
      else
         $display("TESTBENCH FAILED");
      $finish;
   end

   initial
   begin
      wait (cycle_count >= timeout_cycles);
      $display("timeout: stimulus did not finish within %0d cycles", timeout_cycles);
      $display("TESTBENCH FAILED");
      $finish;
   end

endmodule

// ==== theft_fsm.sv ====
module theft_fsm (
   input  logic                    clock_25mhz,
   input  logic                    reset_sync,
   input  logic                    reprogram,
   input  logic                    ignition,
   input  logic                    driver_door,
   input  logic                    passenger_door,
   input  logic                    expired,
   output logic                    start_timer,
   output alarm_pkg::slot_t        delay_select,
   output alarm_pkg::lamp_mode_t   lamp_mode,
   output logic                    alarm,
   output alarm_pkg::theft_state_t theft_state
);

   alarm_pkg::theft_state_t next_state;
   alarm_pkg::slot_t        next_select;
   alarm_pkg::lamp_mode_t   next_lamp;
   logic                    next_start;
   logic                    any_door;

   assign any_door = driver_door || passenger_door;

   ////////////////////////////////////////
   // next state

   always_comb
   begin
      next_state  = theft_state;
      next_select = delay_select;
      next_start  = 1'b0;
      if (reprogram)
      begin
         next_state = alarm_pkg::armed;
      end
      else
      begin
         case (theft_state)
            alarm_pkg::armed:
            begin
               if (ignition)
               begin
                  next_state = alarm_pkg::disarmed;
               end
               else if (driver_door)
               begin
                  next_state  = alarm_pkg::triggered;
                  next_start  = 1'b1;
                  next_select = alarm_pkg::driver_delay;
               end
               else if (passenger_door)
               begin
                  next_state  = alarm_pkg::triggered;
                  next_start  = 1'b1;
                  next_select = alarm_pkg::passenger_delay;
               end
            end
            alarm_pkg::triggered:
            begin
               if (ignition)
                  next_state = alarm_pkg::disarmed;
               else if (expired)
                  next_state = alarm_pkg::sound_alarm;
            end
            alarm_pkg::sound_alarm:
            begin
               if (ignition)
               begin
                  next_state = alarm_pkg::disarmed;
               end
               else if (!any_door)
               begin
                  next_state  = alarm_pkg::expiring_alarm;
                  next_start  = 1'b1;
                  next_select = alarm_pkg::alarm_on;
               end
            end
            alarm_pkg::expiring_alarm:
            begin
               if (ignition)
                  next_state = alarm_pkg::disarmed;
               else if (expired)
                  next_state = alarm_pkg::armed;
               else if (any_door)
                  next_state = alarm_pkg::sound_alarm;  // door reopened, siren again
            end
            alarm_pkg::disarmed:
            begin
               if (!ignition)
                  next_state = alarm_pkg::disarmed_1;
            end
            alarm_pkg::disarmed_1:
            begin
               if (ignition)
                  next_state = alarm_pkg::disarmed;
               else if (driver_door)
                  next_state = alarm_pkg::disarmed_2;
            end
            alarm_pkg::disarmed_2:
            begin
               if (ignition)
               begin
                  next_state = alarm_pkg::disarmed;
               end
               else if (!driver_door)
               begin
                  next_state  = alarm_pkg::disarmed_3;  // driver left, start re-arm delay
                  next_start  = 1'b1;
                  next_select = alarm_pkg::arm_delay;
               end
            end
            alarm_pkg::disarmed_3:
            begin
               // ignition has no priority here
               if (any_door)
                  next_state = alarm_pkg::disarmed;
               else if (expired)
                  next_state = alarm_pkg::armed;
            end
            default:
            begin
               next_state = alarm_pkg::armed;
            end
         endcase
      end
   end

   // lamp follows the state being entered
   always_comb
   begin
      case (next_state)
         alarm_pkg::armed:          next_lamp = alarm_pkg::blinking;
         alarm_pkg::triggered,
         alarm_pkg::sound_alarm,
         alarm_pkg::expiring_alarm: next_lamp = alarm_pkg::constantly_on;
         default:                   next_lamp = alarm_pkg::light_off;
      endcase
   end

   ////////////////////////////////////////
   // registers

   always_ff @(posedge clock_25mhz)
   begin
      if (reset_sync)
      begin
         theft_state  <= alarm_pkg::armed;
         start_timer  <= 1'b0;
         delay_select <= alarm_pkg::arm_delay;
         lamp_mode    <= alarm_pkg::blinking;
         alarm        <= 1'b0;
      end
      else
      begin
         theft_state  <= next_state;
         start_timer  <= next_start;    // single-cycle pulse
         delay_select <= next_select;
         lamp_mode    <= next_lamp;
         alarm        <= (next_state == alarm_pkg::sound_alarm) ||
                         (next_state == alarm_pkg::expiring_alarm);
      end
   end

endmodule
